// ==== common/sha256_params.svh ====
`ifndef SHA256_PARAMS_SVH
`define SHA256_PARAMS_SVH

// compression rounds per block.
`define SHA_ROUNDS        64
`define SHA_WORD_W        32
`define SHA_BLOCK_WORDS   16
`define SHA_DIGEST_WORDS  8

// word addresses, taken from adr[6:2].
`define SHA_ADDR_CTRL     5'd0   // wr: bit0 init, bit1 next. rd: bit0 ready.
`define SHA_ADDR_BLOCK0   5'd1   // block words 1..16.
`define SHA_ADDR_VALID    5'd17  // rd: bit0 digest valid.
`define SHA_ADDR_DIGEST0  5'd18  // digest words 18..25, low word first.

`endif

// ==== common/wb_pkg.sv ====
package wb_pkg;

   // wishbone classic request, as seen by the slave.
   typedef struct packed {
      logic        cyc;
      logic        stb;
      logic        we;
      logic [31:0] adr;
      logic [31:0] dat;
      logic [3:0]  sel;
   } wb_req_t;

   // registered slave response.
   typedef struct packed {
      logic        ack;
      logic [31:0] dat;
   } wb_rsp_t;

endpackage

// ==== common/sha256_pkg.sv ====
`include "sha256_params.svh"

package sha256_pkg;

   typedef logic [`SHA_WORD_W-1:0]                    sha_word_t;
   typedef logic [`SHA_BLOCK_WORDS*`SHA_WORD_W-1:0]   sha_block_t;   // word 0 in low bits.
   typedef logic [`SHA_DIGEST_WORDS*`SHA_WORD_W-1:0]  sha_digest_t;  // h7 in low word.

   typedef enum logic [1:0] {
      OP_NONE = 2'd0,
      OP_INIT = 2'd1,
      OP_NEXT = 2'd2
   } sha_op_e;

   typedef struct packed {
      sha_op_e    op;
      sha_block_t block;
   } sha_cmd_t;

   typedef enum logic [1:0] {
      ST_IDLE  = 2'd0,
      ST_ROUND = 2'd1,
      ST_DONE  = 2'd2
   } sha_state_e;

   // standard initial hash value, h0 in the top word.
   localparam sha_digest_t SHA_H0 = {
      32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
      32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
   };

   localparam sha_word_t SHA_K [64] = '{
      32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
      32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
      32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
      32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
      32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
      32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
      32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
      32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
      32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
      32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
      32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
      32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
      32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
      32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
      32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
      32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
   };

   function automatic sha_word_t sha_k(input logic [5:0] idx);
      return SHA_K[idx];
   endfunction

endpackage

// ==== wb_regs/sha256_wb_regs.sv ====
`timescale 1ns/1ps
`include "sha256_params.svh"

module sha256_wb_regs (
   input  logic                  wb_clk_i,
   input  logic                  wb_rst_i,
   input  wb_pkg::wb_req_t       req_i,
   input  logic                  ready_i,
   input  logic                  digest_valid_i,
   input  sha256_pkg::sha_digest_t digest_i,
   output wb_pkg::wb_rsp_t       rsp_o,
   output sha256_pkg::sha_cmd_t  cmd_o
);
   import sha256_pkg::*;

   sha_word_t  blk_q [`SHA_BLOCK_WORDS];
   logic       ack_q;
   sha_word_t  rd_q;
   sha_op_e    pend_op_q;
   sha_op_e    cmd_op_q;

   logic [4:0] word_adr;
   logic [3:0] blk_idx;
   logic [2:0] dig_idx;
   logic       take;
   logic       is_blk;
   logic       is_dig;
   sha_op_e    wr_op;
   sha_word_t  rd_data;

   assign word_adr = req_i.adr[6:2];
   assign blk_idx  = 4'(word_adr - `SHA_ADDR_BLOCK0);
   assign dig_idx  = 3'(word_adr - `SHA_ADDR_DIGEST0);
   assign is_blk   = (word_adr >= `SHA_ADDR_BLOCK0) && (word_adr < `SHA_ADDR_VALID);
   assign is_dig   = (word_adr >= `SHA_ADDR_DIGEST0) &&
                     (word_adr < `SHA_ADDR_DIGEST0 + 5'd8);

   // one ack per request, dropped even if stb lingers.
   assign take = req_i.cyc && req_i.stb && !ack_q;

   always_comb begin
      if (req_i.dat[0])
         wr_op = OP_INIT;  // init wins over next.
      else if (req_i.dat[1])
         wr_op = OP_NEXT;
      else
         wr_op = OP_NONE;
   end

   always_comb begin
      rd_data = '0;
      if (word_adr == `SHA_ADDR_CTRL)
         rd_data[0] = ready_i;
      else if (is_blk)
         rd_data = blk_q[blk_idx];
      else if (word_adr == `SHA_ADDR_VALID)
         rd_data[0] = digest_valid_i;
      else if (is_dig)
         rd_data = digest_i[`SHA_WORD_W*dig_idx +: `SHA_WORD_W];
   end

   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         ack_q     <= 1'b0;
         pend_op_q <= OP_NONE;
         cmd_op_q  <= OP_NONE;
         for (int i = 0; i < `SHA_BLOCK_WORDS; i++) begin
            blk_q[i] <= '0;
         end
      end else begin
         ack_q     <= take;
         cmd_op_q  <= pend_op_q;  // pulse lands the cycle after ack.
         pend_op_q <= OP_NONE;
         if (take && req_i.we) begin
            if (word_adr == `SHA_ADDR_CTRL && req_i.sel[0])
               pend_op_q <= wr_op;
            if (is_blk) begin
               for (int b = 0; b < 4; b++) begin
                  if (req_i.sel[b])
                     blk_q[blk_idx][8*b +: 8] <= req_i.dat[8*b +: 8];
               end
            end
         end
      end
   end

   // read data, valid while ack is high.
   always_ff @(posedge wb_clk_i) begin
      if (take && !req_i.we)
         rd_q <= rd_data;
   end

   assign rsp_o.ack = ack_q;
   assign rsp_o.dat = rd_q;

   always_comb begin
      cmd_o.op = cmd_op_q;
      for (int i = 0; i < `SHA_BLOCK_WORDS; i++) begin
         cmd_o.block[`SHA_WORD_W*i +: `SHA_WORD_W] = blk_q[i];
      end
   end

   a_ack_single: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      rsp_o.ack |=> !rsp_o.ack);

endmodule

// ==== hash_core/sha256_w_sched.sv ====
`timescale 1ns/1ps
`include "sha256_params.svh"

module sha256_w_sched (
   input  logic                   wb_clk_i,
   input  logic                   wb_rst_i,
   input  logic                   load_i,
   input  sha256_pkg::sha_block_t block_i,
   input  logic                   shift_i,
   output sha256_pkg::sha_word_t  w_o
);
   import sha256_pkg::*;

   // win[0] is the oldest word, w[t-16].
   sha_word_t win_q [`SHA_BLOCK_WORDS];
   sha_word_t w_next;

   function automatic sha_word_t ssig0(input sha_word_t x);
      return {x[6:0], x[31:7]} ^ {x[17:0], x[31:18]} ^ (x >> 3);
   endfunction

   function automatic sha_word_t ssig1(input sha_word_t x);
      return {x[16:0], x[31:17]} ^ {x[18:0], x[31:19]} ^ (x >> 10);
   endfunction

   // w[t] = s1(w[t-2]) + w[t-7] + s0(w[t-15]) + w[t-16].
   assign w_next = ssig1(win_q[14]) + win_q[9] + ssig0(win_q[1]) + win_q[0];

   always_ff @(posedge wb_clk_i) begin
      if (load_i) begin
         for (int i = 0; i < `SHA_BLOCK_WORDS; i++) begin
            win_q[i] <= block_i[`SHA_WORD_W*i +: `SHA_WORD_W];
         end
      end else if (shift_i) begin
         for (int i = 0; i < `SHA_BLOCK_WORDS - 1; i++) begin
            win_q[i] <= win_q[i+1];
         end
         win_q[`SHA_BLOCK_WORDS-1] <= w_next;
      end
   end

   assign w_o = win_q[0];

   a_no_load_shift: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      !(load_i && shift_i));

endmodule

// ==== hash_core/sha256_rounds.sv ====
`timescale 1ns/1ps
`include "sha256_params.svh"

module sha256_rounds (
   input  logic                    wb_clk_i,
   input  logic                    wb_rst_i,
   input  sha256_pkg::sha_cmd_t    cmd_i,
   input  sha256_pkg::sha_word_t   w_i,
   output logic                    load_o,
   output sha256_pkg::sha_block_t  block_o,
   output logic                    shift_o,
   output logic                    ready_o,
   output logic                    digest_valid_o,
   output sha256_pkg::sha_digest_t digest_o
);
   import sha256_pkg::*;

   sha_state_e  state_q;
   logic [6:0]  cnt_q;
   logic        load_q;
   sha_block_t  block_q;
   sha_digest_t chain_q;
   sha_word_t   a_q, b_q, c_q, d_q, e_q, f_q, g_q, h_q;

   logic        accept;
   logic        round_en;
   sha_digest_t seed;
   sha_word_t   t1, t2;

   function automatic sha_word_t bsig0(input sha_word_t x);
      return {x[1:0], x[31:2]} ^ {x[12:0], x[31:13]} ^ {x[21:0], x[31:22]};
   endfunction

   function automatic sha_word_t bsig1(input sha_word_t x);
      return {x[5:0], x[31:6]} ^ {x[10:0], x[31:11]} ^ {x[24:0], x[31:25]};
   endfunction

   function automatic sha_word_t ch(input sha_word_t x, input sha_word_t y,
                                    input sha_word_t z);
      return (x & y) ^ (~x & z);
   endfunction

   function automatic sha_word_t maj(input sha_word_t x, input sha_word_t y,
                                     input sha_word_t z);
      return (x & y) ^ (x & z) ^ (y & z);
   endfunction

   assign ready_o        = (state_q == ST_IDLE) || (state_q == ST_DONE);
   assign digest_valid_o = (state_q == ST_DONE);
   assign accept         = ready_o && (cmd_i.op != OP_NONE);
   assign seed           = (cmd_i.op == OP_INIT) ? SHA_H0 : chain_q;

   // load cycle first, then one round per cycle.
   assign round_en = (state_q == ST_ROUND) && !load_q && (cnt_q < `SHA_ROUNDS);

   assign t1 = h_q + bsig1(e_q) + ch(e_q, f_q, g_q) + sha_k(cnt_q[5:0]) + w_i;
   assign t2 = bsig0(a_q) + maj(a_q, b_q, c_q);

   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         state_q <= ST_IDLE;
         cnt_q   <= '0;
         load_q  <= 1'b0;
         chain_q <= SHA_H0;
      end else begin
         load_q <= 1'b0;
         case (state_q)
            ST_IDLE, ST_DONE: begin
               if (accept) begin
                  state_q <= ST_ROUND;
                  cnt_q   <= '0;
                  load_q  <= 1'b1;
                  if (cmd_i.op == OP_INIT)
                     chain_q <= SHA_H0;
               end
            end
            ST_ROUND: begin
               if (round_en) begin
                  cnt_q <= cnt_q + 7'd1;
               end else if (!load_q) begin
                  // all rounds done, fold into chaining value.
                  chain_q <= {chain_q[255:224] + a_q, chain_q[223:192] + b_q,
                              chain_q[191:160] + c_q, chain_q[159:128] + d_q,
                              chain_q[127:96]  + e_q, chain_q[95:64]   + f_q,
                              chain_q[63:32]   + g_q, chain_q[31:0]    + h_q};
                  state_q <= ST_DONE;
               end
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (accept) begin
         block_q <= cmd_i.block;
         {a_q, b_q, c_q, d_q, e_q, f_q, g_q, h_q} <= seed;
      end else if (round_en) begin
         h_q <= g_q;
         g_q <= f_q;
         f_q <= e_q;
         e_q <= d_q + t1;
         d_q <= c_q;
         c_q <= b_q;
         b_q <= a_q;
         a_q <= t1 + t2;
      end
   end

   assign load_o   = load_q;
   assign block_o  = block_q;
   assign shift_o  = round_en;  // next w ready for the next round.
   assign digest_o = chain_q;

   a_valid_ready: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      digest_valid_o |-> ready_o);

   a_cnt_range: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      (state_q == ST_ROUND) |-> (cnt_q <= `SHA_ROUNDS));

endmodule

// ==== hdl/sha256_top.sv ====
`timescale 1ns/1ps

module sha256_top (
   input  logic        wb_clk_i,
   input  logic        wb_rst_i,
   input  logic        wb_cyc_i,
   input  logic        wb_stb_i,
   input  logic        wb_we_i,
   input  logic [31:0] wb_adr_i,
   input  logic [31:0] wb_dat_i,
   input  logic [3:0]  wb_sel_i,
   output logic        wb_ack_o,
   output logic [31:0] wb_dat_o
);
   import wb_pkg::*;
   import sha256_pkg::*;

   wb_req_t     req;
   wb_rsp_t     rsp;
   sha_cmd_t    cmd;
   sha_block_t  sched_block;
   sha_word_t   w;
   sha_digest_t digest;
   logic        ready;
   logic        digest_valid;
   logic        load;
   logic        shift;

   assign req = '{cyc: wb_cyc_i, stb: wb_stb_i, we: wb_we_i,
                  adr: wb_adr_i, dat: wb_dat_i, sel: wb_sel_i};

   assign wb_ack_o = rsp.ack;
   assign wb_dat_o = rsp.dat;

   sha256_wb_regs u_regs (
      .wb_clk_i       (wb_clk_i),
      .wb_rst_i       (wb_rst_i),
      .req_i          (req),
      .ready_i        (ready),
      .digest_valid_i (digest_valid),
      .digest_i       (digest),
      .rsp_o          (rsp),
      .cmd_o          (cmd)
   );

   sha256_w_sched u_sched (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .load_i   (load),
      .block_i  (sched_block),
      .shift_i  (shift),
      .w_o      (w)
   );

   sha256_rounds u_rounds (
      .wb_clk_i       (wb_clk_i),
      .wb_rst_i       (wb_rst_i),
      .cmd_i          (cmd),
      .w_i            (w),
      .load_o         (load),
      .block_o        (sched_block),
      .shift_o        (shift),
      .ready_o        (ready),
      .digest_valid_o (digest_valid),
      .digest_o       (digest)
   );

endmodule

// ==== dv/sha256_ref.svh ====
`ifndef SHA256_REF_SVH
`define SHA256_REF_SVH

// round constants and initial hash value, fips 180-4.
localparam logic [31:0] REF_K [64] = '{
   32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5, 32'h3956c25b, 32'h59f111f1,
   32'h923f82a4, 32'hab1c5ed5, 32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
   32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174, 32'he49b69c1, 32'hefbe4786,
   32'h0fc19dc6, 32'h240ca1cc, 32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
   32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7, 32'hc6e00bf3, 32'hd5a79147,
   32'h06ca6351, 32'h14292967, 32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
   32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85, 32'ha2bfe8a1, 32'ha81a664b,
   32'hc24b8b70, 32'hc76c51a3, 32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
   32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5, 32'h391c0cb3, 32'h4ed8aa4a,
   32'h5b9cca4f, 32'h682e6ff3, 32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
   32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
};

localparam logic [255:0] REF_IV = {
   32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
   32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
};

function automatic logic [31:0] rotr(input logic [31:0] x, input int n);
   return (x >> n) | (x << (32 - n));
endfunction

function automatic logic [31:0] xorshift32(input logic [31:0] s);
   s = s ^ (s << 13);
   s = s ^ (s >> 17);
   s = s ^ (s << 5);
   return s;
endfunction

// one compression step, h0 in the top word, block word 0 in the low bits.
function automatic logic [255:0] ref_compress(input logic [255:0] hin,
                                              input logic [511:0] blk);
   logic [31:0]  w [64];
   logic [31:0]  v [8];
   logic [31:0]  s0, s1, t1, t2;
   logic [255:0] hout;
   for (int t = 0; t < 16; t++)
      w[t] = blk[32*t +: 32];
   for (int t = 16; t < 64; t++) begin
      s0   = rotr(w[t-15], 7) ^ rotr(w[t-15], 18) ^ (w[t-15] >> 3);
      s1   = rotr(w[t-2], 17) ^ rotr(w[t-2], 19) ^ (w[t-2] >> 10);
      w[t] = s1 + w[t-7] + s0 + w[t-16];
   end
   for (int i = 0; i < 8; i++)
      v[i] = hin[255 - 32*i -: 32];
   for (int t = 0; t < 64; t++) begin
      s1 = rotr(v[4], 6) ^ rotr(v[4], 11) ^ rotr(v[4], 25);
      t1 = v[7] + s1 + ((v[4] & v[5]) ^ (~v[4] & v[6])) + REF_K[t] + w[t];
      s0 = rotr(v[0], 2) ^ rotr(v[0], 13) ^ rotr(v[0], 22);
      t2 = s0 + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
      for (int i = 7; i > 0; i--)
         v[i] = v[i-1];
      v[4] = v[4] + t1;  // old d plus t1.
      v[0] = t1 + t2;
   end
   for (int i = 0; i < 8; i++)
      hout[255 - 32*i -: 32] = hin[255 - 32*i -: 32] + v[i];
   return hout;
endfunction

`endif

// ==== dv/sha256_tb.sv ====
`timescale 1ns/1ps
`include "sha256_params.svh"

module sha256_tb;
   import sha256_pkg::*;

   `include "sha256_ref.svh"

   localparam int LATENCY   = `SHA_ROUNDS + 2;  // load, rounds, fold.
   localparam int ACK_BOUND = 4;
   localparam int NUM_TESTS = 6;
   localparam int WATCHDOG_CYCLES = NUM_TESTS * (LATENCY + 40 * 3) * 2;
   localparam logic [255:0] ABC_DIGEST = {
      32'hba7816bf, 32'h8f01cfea, 32'h414140de, 32'h5dae2223,
      32'hb00361a3, 32'h96177a9c, 32'hb410ff61, 32'hf20015ad
   };

   logic        wb_clk;
   logic        wb_rst;
   logic        wb_cyc;
   logic        wb_stb;
   logic        wb_we;
   logic [31:0] wb_adr;
   logic [31:0] wb_dat;
   logic [3:0]  wb_sel;
   logic        wb_ack;
   logic [31:0] wb_dat_o;
   int          errors;
   int          errs_at_start;
   int          tests_run;
   int          tests_bad;
   string       cur_test;
   logic [31:0] rng;

   sha256_top dut (
      .wb_clk_i (wb_clk),
      .wb_rst_i (wb_rst),
      .wb_cyc_i (wb_cyc),
      .wb_stb_i (wb_stb),
      .wb_we_i  (wb_we),
      .wb_adr_i (wb_adr),
      .wb_dat_i (wb_dat),
      .wb_sel_i (wb_sel),
      .wb_ack_o (wb_ack),
      .wb_dat_o (wb_dat_o)
   );

   always #5 wb_clk = ~wb_clk;

   a_ack_next: assert property (@(posedge wb_clk) disable iff (wb_rst)
      (wb_cyc && wb_stb && !wb_ack) |=> wb_ack)
      else begin
         errors++;
         $display("ERROR: request not acknowledged in the next cycle in %s", cur_test);
      end

   a_ack_single: assert property (@(posedge wb_clk) disable iff (wb_rst)
      wb_ack |=> !wb_ack)
      else begin
         errors++;
         $display("ERROR: ack held high for two cycles in %s", cur_test);
      end

   a_ready_falls: assert property (@(posedge wb_clk) disable iff (wb_rst)
      (dut.cmd.op != OP_NONE && dut.ready) |=> !dut.ready)
      else begin
         errors++;
         $display("ERROR: ready stayed high after an accepted command in %s", cur_test);
      end

   a_latency: assert property (@(posedge wb_clk) disable iff (wb_rst)
      (dut.cmd.op != OP_NONE && dut.ready) |=>
         (!dut.digest_valid [*LATENCY] ##1 dut.digest_valid))
      else begin
         errors++;
         $display("ERROR: digest_valid not set exactly %0d cycles after command in %s",
                  LATENCY, cur_test);
      end

   task automatic bus_cycle(input logic write, input int word, input logic [31:0] data,
                            input logic [3:0] be, output logic [31:0] rdata);
      int waits;
      waits = 0;
      @(negedge wb_clk);
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      wb_we  = write;
      wb_adr = word * 4;
      wb_dat = data;
      wb_sel = be;
      @(negedge wb_clk);
      while (!wb_ack && waits < ACK_BOUND) begin
         waits++;
         @(negedge wb_clk);
      end
      if (!wb_ack) begin
         errors++;
         $display("ERROR: no ack for access to word %0d in %s", word, cur_test);
      end
      rdata  = wb_dat_o;  // read data is valid while ack is high.
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic write_word(input int word, input logic [31:0] data, input logic [3:0] be);
      logic [31:0] unused;
      bus_cycle(1'b1, word, data, be, unused);
   endtask

   task automatic read_word(input int word, output logic [31:0] data);
      bus_cycle(1'b0, word, 32'h0, 4'hf, data);
   endtask

   task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) begin
         errors++;
         $display("FAILED %s %s: expected %08h, actual %08h", cur_test, what, exp, act);
      end
   endtask

   task automatic write_block(input logic [511:0] blk);
      for (int i = 0; i < 16; i++)
         write_word(`SHA_ADDR_BLOCK0 + i, blk[32*i +: 32], 4'hf);
   endtask

   function automatic logic [511:0] random_block();
      logic [511:0] blk;
      for (int i = 0; i < 16; i++) begin
         rng = xorshift32(rng);
         blk[32*i +: 32] = rng;
      end
      return blk;
   endfunction

   // control write followed by the command pulse and its acceptance.
   task automatic start_cmd(input logic [31:0] ctrl);
      write_word(`SHA_ADDR_CTRL, ctrl, 4'hf);
      repeat (2) @(negedge wb_clk);
   endtask

   task automatic wait_valid();
      logic [31:0] v;
      int          polls;
      v     = '0;
      polls = 0;
      while (v[0] !== 1'b1 && polls < LATENCY) begin
         read_word(`SHA_ADDR_VALID, v);
         polls++;
      end
      if (v[0] !== 1'b1) begin
         errors++;
         $display("ERROR: digest_valid never set in %s", cur_test);
      end
   endtask

   task automatic check_digest(input logic [255:0] exp);
      logic [31:0] got;
      for (int i = 0; i < 8; i++) begin
         read_word(`SHA_ADDR_DIGEST0 + i, got);
         check_eq($sformatf("digest word %0d", i), exp[32*i +: 32], got);
      end
   endtask

   task automatic open_test(input string name);
      cur_test      = name;
      errs_at_start = errors;
   endtask

   task automatic close_test();
      tests_run++;
      if (errors == errs_at_start) begin
         $display("test %s: ok", cur_test);
      end else begin
         tests_bad++;
         $display("test %s: %0d errors", cur_test, errors - errs_at_start);
      end
   endtask

   initial begin
      #(WATCHDOG_CYCLES * 10);
      $display("ERROR: watchdog expired after %0d cycles in %s", WATCHDOG_CYCLES, cur_test);
      $display("TESTS FAILED");
      $finish;
   end

   initial begin
      logic [511:0] b1;
      logic [511:0] b2;
      logic [31:0]  got;
      logic [31:0]  exp;
      logic [31:0]  newv;
      logic [3:0]   be;
      errors    = 0;
      tests_run = 0;
      tests_bad = 0;
      cur_test  = "reset";
      rng       = 32'hc77b;
      wb_clk    = 1'b0;
      wb_rst    = 1'b1;
      wb_cyc    = 1'b0;
      wb_stb    = 1'b0;
      wb_we     = 1'b0;
      wb_adr    = '0;
      wb_dat    = '0;
      wb_sel    = '0;
      repeat (4) @(posedge wb_clk);
      @(negedge wb_clk);
      wb_rst = 1'b0;

      open_test("reset_values");
      read_word(`SHA_ADDR_CTRL, got);
      check_eq("ready", 32'd1, got);
      read_word(`SHA_ADDR_VALID, got);
      check_eq("digest_valid", 32'd0, got);
      for (int i = 0; i < 16; i++) begin
         read_word(`SHA_ADDR_BLOCK0 + i, got);
         check_eq($sformatf("block word %0d", i), 32'd0, got);
      end
      close_test();

      open_test("block_readback");
      b1 = random_block();
      write_block(b1);
      for (int i = 0; i < 16; i++) begin
         read_word(`SHA_ADDR_BLOCK0 + i, got);
         check_eq($sformatf("block word %0d", i), b1[32*i +: 32], got);
      end
      for (int i = 0; i < 16; i++) begin
         rng  = xorshift32(rng);
         newv = rng;
         rng  = xorshift32(rng);
         be   = rng[3:0];
         exp  = b1[32*i +: 32];
         for (int b = 0; b < 4; b++)
            if (be[b])
               exp[8*b +: 8] = newv[8*b +: 8];
         write_word(`SHA_ADDR_BLOCK0 + i, newv, be);
         read_word(`SHA_ADDR_BLOCK0 + i, got);
         check_eq($sformatf("byte write word %0d", i), exp, got);
      end
      close_test();

      open_test("abc_digest");
      b1 = '0;
      b1[31:0]    = 32'h61626380;  // "abc" and the pad bit.
      b1[511:480] = 32'h00000018;  // message length in bits.
      write_block(b1);
      start_cmd(32'd1);
      read_word(`SHA_ADDR_CTRL, got);
      check_eq("ready while busy", 32'd0, got);
      wait_valid();
      check_digest(ABC_DIGEST);
      close_test();

      open_test("two_block_chain");
      b1 = random_block();
      b2 = random_block();
      write_block(b1);
      start_cmd(32'd1);
      write_block(b2);
      wait_valid();
      start_cmd(32'd2);
      wait_valid();
      check_digest(ref_compress(ref_compress(REF_IV, b1), b2));
      close_test();

      open_test("busy_drop");
      b1 = random_block();
      b2 = random_block();
      write_block(b1);
      start_cmd(32'd1);
      read_word(`SHA_ADDR_CTRL, got);
      check_eq("ready during rounds", 32'd0, got);
      write_block(b2);   // new block data for the second command.
      start_cmd(32'd2);  // engine still busy so this is dropped.
      read_word(`SHA_ADDR_CTRL, got);
      check_eq("ready after dropped command", 32'd0, got);
      wait_valid();
      check_digest(ref_compress(REF_IV, b1));
      read_word(`SHA_ADDR_CTRL, got);
      check_eq("ready when done", 32'd1, got);
      close_test();

      open_test("bus_timing");
      read_word(26, got);
      check_eq("unmapped word 26", 32'd0, got);
      read_word(31, got);
      check_eq("unmapped word 31", 32'd0, got);
      write_word(28, 32'hffffffff, 4'hf);
      @(negedge wb_clk);
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      wb_adr = `SHA_ADDR_VALID * 4;
      @(negedge wb_clk);
      check_eq("ack on held strobe", 32'd1, {31'd0, wb_ack});
      @(negedge wb_clk);
      check_eq("ack dropped under held strobe", 32'd0, {31'd0, wb_ack});
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      repeat (2) @(negedge wb_clk);
      close_test();

      $display("summary: %0d tests run, %0d with errors, %0d errors in all",
               tests_run, tests_bad, errors);
      if (errors == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule

// ==== tb.f ====
+incdir+common
+incdir+dv
common/wb_pkg.sv
common/sha256_pkg.sv
wb_regs/sha256_wb_regs.sv
hash_core/sha256_w_sched.sv
hash_core/sha256_rounds.sv
hdl/sha256_top.sv
dv/sha256_tb.sv
